// ==== mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Datapath and register file
`define MIPS_XLEN 32
`define MIPS_REG_COUNT 32

// Memories, depth in words
`define MIPS_DMEM_WORDS 128           // 512 bytes
`define MIPS_ROM_WORDS 128

// Byte addresses inside data memory
`define MIPS_STACK_BEGIN 256          // Stack grows down from here
`define MIPS_OUT_ADDR 256             // Byte store here drives the output port
`define MIPS_IN_ADDR 272              // External input lands in this word

// I/O port widths
`define MIPS_IN_WIDTH 12
`define MIPS_OUT_WIDTH 8

`endif

// ==== mipsPkg.sv ====
`include "mips_cfg.svh"

package mipsPkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] regAddr_t;
    typedef logic [5:0] opcode_t;                    // instr[31:26]
    typedef logic [5:0] funct_t;                     // instr[5:0]
    typedef logic [`MIPS_OUT_WIDTH-1:0] outByte_t;
    typedef logic [`MIPS_IN_WIDTH-1:0] inData_t;

    // Encodings kept from the original ALU control
    typedef enum logic [3:0] {
        ALU_SLL  = 4'b0000,
        ALU_SRL  = 4'b0001,
        ALU_SRA  = 4'b0010,
        ALU_LUI  = 4'b0011,
        ALU_MUL  = 4'b0100,
        ALU_ADD  = 4'b0110,
        ALU_ADDU = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SUBU = 4'b1001,
        ALU_AND  = 4'b1010,
        ALU_OR   = 4'b1011,
        ALU_XOR  = 4'b1100,
        ALU_NOR  = 4'b1101,
        ALU_SLT  = 4'b1110,
        ALU_SLTU = 4'b1111
    } aluOp_t;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} memWidth_t;
    typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} regDst_t;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wbSel_t;
    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ} branchKind_t;

    typedef struct packed {
        logic zero;
        logic sign;                                  // Result bit 31
    } aluFlags_t;

    typedef struct packed {
        logic      regWrite;
        regDst_t   regDst;
        logic      aluSrcImm;                        // Operand b from immediate
        logic      shiftByShamt;                     // Operand a from shamt field
        aluOp_t    aluOp;
        logic      memWrite;
        logic      memSigned;
        memWidth_t memWidth;
        wbSel_t    wbSel;
        logic      jump;
        logic      jumpReg;                          // JR, JALR
        logic      pcSrc;                            // Branch taken
    } ctrl_t;

    typedef struct packed {
        word_t     addr;
        word_t     wdata;
        logic      write;
        memWidth_t width;
        logic      isSigned;                         // Sign extend on load
    } memReq_t;

endpackage

// ==== controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit (
    input  mipsPkg::opcode_t   opcode,
    input  mipsPkg::funct_t    funct,
    input  mipsPkg::aluFlags_t flags,
    output mipsPkg::ctrl_t     ctrl
);

    mipsPkg::branchKind_t branchKind;
    mipsPkg::memWidth_t accessWidth;

    // Loads and stores share the width in opcode[1:0]
    assign accessWidth = (opcode[1:0] == 2'b00) ? mipsPkg::MEM_BYTE :
                         (opcode[1:0] == 2'b01) ? mipsPkg::MEM_HALF : mipsPkg::MEM_WORD;

    always_comb begin
        ctrl = '0;                                   // Unknown encodings do nothing
        branchKind = mipsPkg::BR_NONE;
        case (opcode)
            6'b000000: begin                         // SPECIAL
                ctrl.regWrite = 1'b1;
                ctrl.regDst = mipsPkg::DST_RD;
                ctrl.shiftByShamt = (funct[5:2] == 4'b0000); // SLL, SRL, SRA
                case (funct)
                    6'b000000, 6'b000100: ctrl.aluOp = mipsPkg::ALU_SLL; // Also SLLV
                    6'b000010, 6'b000110: ctrl.aluOp = mipsPkg::ALU_SRL;
                    6'b000011, 6'b000111: ctrl.aluOp = mipsPkg::ALU_SRA;
                    6'b001000: begin                 // JR
                        ctrl.regWrite = 1'b0;
                        ctrl.jump = 1'b1;
                        ctrl.jumpReg = 1'b1;
                    end
                    6'b001001: begin                 // JALR, link into rd
                        ctrl.jump = 1'b1;
                        ctrl.jumpReg = 1'b1;
                        ctrl.wbSel = mipsPkg::WB_LINK;
                    end
                    6'b100000: ctrl.aluOp = mipsPkg::ALU_ADD;
                    6'b100001: ctrl.aluOp = mipsPkg::ALU_ADDU;
                    6'b100010: ctrl.aluOp = mipsPkg::ALU_SUB;
                    6'b100011: ctrl.aluOp = mipsPkg::ALU_SUBU;
                    6'b100100: ctrl.aluOp = mipsPkg::ALU_AND;
                    6'b100101: ctrl.aluOp = mipsPkg::ALU_OR;
                    6'b100110: ctrl.aluOp = mipsPkg::ALU_XOR;
                    6'b100111: ctrl.aluOp = mipsPkg::ALU_NOR;
                    6'b101010: ctrl.aluOp = mipsPkg::ALU_SLT;
                    6'b101011: ctrl.aluOp = mipsPkg::ALU_SLTU;
                    default: ctrl = '0;
                endcase
            end
            6'b000100: branchKind = mipsPkg::BR_EQ;
            6'b000101: branchKind = mipsPkg::BR_NE;
            6'b000110: branchKind = mipsPkg::BR_LEZ; // rt field is zero
            6'b000111: branchKind = mipsPkg::BR_GTZ;
            6'b001000, 6'b001001, 6'b001010, 6'b001011,
            6'b001100, 6'b001101, 6'b001110, 6'b001111: begin
                ctrl.regWrite = 1'b1;                // Immediate ALU ops into rt
                ctrl.aluSrcImm = 1'b1;
                case (opcode[2:0])
                    3'b000: ctrl.aluOp = mipsPkg::ALU_ADD;
                    3'b001: ctrl.aluOp = mipsPkg::ALU_ADDU;
                    3'b010: ctrl.aluOp = mipsPkg::ALU_SLT;
                    3'b011: ctrl.aluOp = mipsPkg::ALU_SLTU;
                    3'b100: ctrl.aluOp = mipsPkg::ALU_AND;
                    3'b101: ctrl.aluOp = mipsPkg::ALU_OR;
                    3'b110: ctrl.aluOp = mipsPkg::ALU_XOR;
                    default: ctrl.aluOp = mipsPkg::ALU_LUI;
                endcase
            end
            6'b011100: begin                         // SPECIAL2, only MUL
                if (funct == 6'b000010) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regDst = mipsPkg::DST_RD;
                    ctrl.aluOp = mipsPkg::ALU_MUL;
                end
            end
            6'b100000, 6'b100001, 6'b100011, 6'b100100, 6'b100101: begin
                ctrl.regWrite = 1'b1;                // LB LH LW LBU LHU
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = mipsPkg::ALU_ADD;
                ctrl.wbSel = mipsPkg::WB_MEM;
                ctrl.memSigned = ~opcode[2];         // Unsigned forms have bit 2 set
                ctrl.memWidth = accessWidth;
            end
            6'b101000, 6'b101001, 6'b101011: begin   // SB SH SW
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = mipsPkg::ALU_ADD;
                ctrl.memWidth = accessWidth;
            end
            6'b000010: ctrl.jump = 1'b1;             // J
            6'b000011: begin                         // JAL
                ctrl.jump = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.regDst = mipsPkg::DST_RA;
                ctrl.wbSel = mipsPkg::WB_LINK;
            end
            default: ctrl = '0;
        endcase

        // Branches compare rs - rt
        if (branchKind != mipsPkg::BR_NONE) ctrl.aluOp = mipsPkg::ALU_SUB;
        case (branchKind)
            mipsPkg::BR_EQ:  ctrl.pcSrc = flags.zero;
            mipsPkg::BR_NE:  ctrl.pcSrc = ~flags.zero;
            mipsPkg::BR_LEZ: ctrl.pcSrc = flags.zero | flags.sign;
            mipsPkg::BR_GTZ: ctrl.pcSrc = ~(flags.zero | flags.sign);
            default:         ctrl.pcSrc = 1'b0;
        endcase
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ns

module regFile (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  mipsPkg::regAddr_t waddr,
    input  mipsPkg::regAddr_t raddr1,
    input  mipsPkg::regAddr_t raddr2,
    input  mipsPkg::word_t    wdata,
    output mipsPkg::word_t    rdata1,
    output mipsPkg::word_t    rdata2
);

    localparam int Depth = 2 ** $bits(mipsPkg::regAddr_t);

    mipsPkg::word_t regs [Depth];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < Depth; i++) regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;                    // $zero never written
        end
    end

    // Combinational reads, register 0 hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== alu.sv ====
`timescale 1ns/1ns

module alu (
    input  mipsPkg::word_t     a,
    input  mipsPkg::word_t     b,
    input  mipsPkg::aluOp_t    op,
    output mipsPkg::word_t     result,
    output mipsPkg::aluFlags_t flags
);

    logic [4:0] shamt;

    assign shamt = a[4:0];                           // Shift count always from a

    always_comb begin
        case (op)
            mipsPkg::ALU_SLL:  result = b << shamt;
            mipsPkg::ALU_SRL:  result = b >> shamt;
            mipsPkg::ALU_SRA:  result = $signed(b) >>> shamt;
            mipsPkg::ALU_LUI:  result = {b[15:0], 16'b0};
            mipsPkg::ALU_MUL:  result = $signed(a) * $signed(b); // Low word only
            mipsPkg::ALU_ADD,
            mipsPkg::ALU_ADDU: result = a + b;       // No overflow trap
            mipsPkg::ALU_SUB,
            mipsPkg::ALU_SUBU: result = a - b;
            mipsPkg::ALU_AND:  result = a & b;
            mipsPkg::ALU_OR:   result = a | b;
            mipsPkg::ALU_XOR:  result = a ^ b;
            mipsPkg::ALU_NOR:  result = ~(a | b);
            mipsPkg::ALU_SLT:  result = mipsPkg::word_t'($signed(a) < $signed(b));
            mipsPkg::ALU_SLTU: result = mipsPkg::word_t'(a < b);
            default:           result = '0;
        endcase
    end

    // Flags for branch resolution
    assign flags.zero = (result == '0);
    assign flags.sign = result[$bits(mipsPkg::word_t)-1];

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module datapath (
    input  logic               clk,
    input  logic               rst,
    input  mipsPkg::word_t     instr,
    input  mipsPkg::ctrl_t     ctrl,
    input  mipsPkg::word_t     rdata,
    output mipsPkg::word_t     pc,
    output mipsPkg::opcode_t   opcode,
    output mipsPkg::funct_t    funct,
    output mipsPkg::aluFlags_t flags,
    output mipsPkg::memReq_t   memReq
);

    mipsPkg::word_t pcPlus4, pcNext, branchTarget, jumpTarget;
    mipsPkg::word_t imm, rsData, rtData, srcA, srcB, aluResult, writeData;
    mipsPkg::regAddr_t writeReg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) pc <= '0;
        else     pc <= pcNext;
    end

    assign pcPlus4 = pc + 32'd4;
    assign imm = {{16{instr[15]}}, instr[15:0]};            // Sign extended
    assign branchTarget = pcPlus4 + {imm[`MIPS_XLEN-3:0], 2'b00};
    assign jumpTarget = {pcPlus4[`MIPS_XLEN-1 -: 4], instr[25:0], 2'b00};

    // Jumps first, then taken branch
    assign pcNext = ctrl.jump  ? (ctrl.jumpReg ? rsData : jumpTarget) :
                    ctrl.pcSrc ? branchTarget : pcPlus4;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    // Immediate shifts take shamt in place of rs
    assign srcA = ctrl.shiftByShamt ? mipsPkg::word_t'(instr[10:6]) : rsData;
    assign srcB = ctrl.aluSrcImm ? imm : rtData;

    always_comb begin
        case (ctrl.regDst)
            mipsPkg::DST_RD: writeReg = instr[15:11];
            mipsPkg::DST_RA: writeReg = 5'd31;       // JAL link
            default:         writeReg = instr[20:16];
        endcase
        case (ctrl.wbSel)
            mipsPkg::WB_MEM:  writeData = rdata;
            mipsPkg::WB_LINK: writeData = pcPlus4;
            default:          writeData = aluResult;
        endcase
    end

    regFile i_regFile (
        .clk    (clk),
        .rst    (rst),
        .we     (ctrl.regWrite),
        .waddr  (writeReg),
        .raddr1 (instr[25:21]),
        .raddr2 (instr[20:16]),
        .wdata  (writeData),
        .rdata1 (rsData),
        .rdata2 (rtData)
    );

    alu i_alu (
        .a      (srcA),
        .b      (srcB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .flags  (flags)
    );

    // Store data always from rt
    assign memReq.addr     = aluResult;
    assign memReq.wdata    = rtData;
    assign memReq.write    = ctrl.memWrite;
    assign memReq.width    = ctrl.memWidth;
    assign memReq.isSigned = ctrl.memSigned;

endmodule

// ==== programRom.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module programRom (
    input  mipsPkg::word_t addr,
    output mipsPkg::word_t instr
);

    // Register names
    localparam mipsPkg::regAddr_t zero = 5'd0;
    localparam mipsPkg::regAddr_t v0 = 5'd2;         // Return value
    localparam mipsPkg::regAddr_t a0 = 5'd4;
    localparam mipsPkg::regAddr_t a1 = 5'd5;
    localparam mipsPkg::regAddr_t a2 = 5'd6;
    localparam mipsPkg::regAddr_t a3 = 5'd7;
    localparam mipsPkg::regAddr_t t0 = 5'd8;
    localparam mipsPkg::regAddr_t t1 = 5'd9;
    localparam mipsPkg::regAddr_t t2 = 5'd10;
    localparam mipsPkg::regAddr_t s0 = 5'd16;        // Current LCG value
    localparam mipsPkg::regAddr_t sp = 5'd29;
    localparam mipsPkg::regAddr_t ra = 5'd31;

    localparam mipsPkg::opcode_t opSpecial = 6'b000000;
    localparam mipsPkg::opcode_t opMul = 6'b011100;  // SPECIAL2
    localparam mipsPkg::opcode_t opAddi = 6'b001000;
    localparam mipsPkg::opcode_t opOri = 6'b001101;
    localparam mipsPkg::opcode_t opBeq = 6'b000100;
    localparam mipsPkg::opcode_t opBlez = 6'b000110;
    localparam mipsPkg::opcode_t opBgtz = 6'b000111;
    localparam mipsPkg::opcode_t opJal = 6'b000011;
    localparam mipsPkg::opcode_t opLbu = 6'b100100;
    localparam mipsPkg::opcode_t opLw = 6'b100011;
    localparam mipsPkg::opcode_t opSb = 6'b101000;
    localparam mipsPkg::opcode_t opSw = 6'b101011;
    localparam mipsPkg::funct_t fnJr = 6'b001000;
    localparam mipsPkg::funct_t fnJalr = 6'b001001;
    localparam mipsPkg::funct_t fnAdd = 6'b100000;
    localparam mipsPkg::funct_t fnAddu = 6'b100001;
    localparam mipsPkg::funct_t fnSub = 6'b100010;
    localparam mipsPkg::funct_t fnOr = 6'b100101;
    localparam mipsPkg::funct_t fnMul = 6'b000010;

    localparam mipsPkg::word_t ret = {opSpecial, ra, 15'd0, fnJr};
    localparam int IdxBits = $clog2(`MIPS_ROM_WORDS);

    logic [IdxBits-1:0] wordIdx;
    logic inRange;

    assign wordIdx = addr[IdxBits+1:2];
    assign inRange = (addr[`MIPS_XLEN-1:2] < `MIPS_ROM_WORDS);

    always_comb begin
        instr = '0;                                  // NOP outside the program
        if (inRange) begin
            case (wordIdx)
                0:  instr = {opAddi, zero, sp, 16'(`MIPS_STACK_BEGIN)};
                3:  instr = {opLbu, zero, s0, 16'(`MIPS_IN_ADDR)};  // Seed, low byte
                10: instr = {opOri, s0, a1, 16'd0};              // Loop, seed arg
                11: instr = {opAddi, zero, a0, 16'd17};          // Multiplier
                12: instr = {opAddi, zero, a2, 16'd3};           // Increment
                13: instr = {opAddi, zero, a3, 16'd256};         // Modulus
                14: instr = {opJal, 26'd50};
                15: instr = {opOri, v0, s0, 16'd0};
                16: instr = {opSb, zero, v0, 16'(`MIPS_OUT_ADDR)};
                17: instr = {opBeq, zero, zero, 16'hfff8};       // Back to 10
                50: instr = {opMul, a1, a0, t0, 5'd0, fnMul};    // lcg()
                51: instr = {opSpecial, a2, t0, t0, 5'd0, fnAddu};
                52: instr = {opOri, t0, a0, 16'd0};
                53: instr = {opSpecial, zero, a3, a1, 5'd0, fnOr};
                54: instr = {opAddi, sp, sp, 16'hfffc};          // Push ra
                55: instr = {opSw, sp, ra, 16'd0};
                56: instr = {opOri, zero, t2, 16'(80 * 4)};
                57: instr = {opSpecial, t2, zero, ra, 5'd0, fnJalr}; // mod()
                58: instr = {opLw, sp, ra, 16'd0};               // Pop ra
                59: instr = {opAddi, sp, sp, 16'd4};
                60: instr = ret;
                80: instr = {opAddi, a0, v0, 16'd0};              // mod(), v0 = a0 % a1
                81: instr = {opSpecial, a1, v0, t0, 5'd0, fnSub};
                82: instr = {opSpecial, zero, v0, t1, 5'd0, fnSub};
                83: instr = {opBlez, t0, 5'd0, 16'd2};           // v0 >= m
                84: instr = {opBgtz, t1, 5'd0, 16'd3};           // v0 < 0
                85: instr = ret;
                86: instr = {opSpecial, v0, a1, v0, 5'd0, fnSub};
                87: instr = {opBeq, zero, zero, 16'hfff9};
                88: instr = {opSpecial, v0, a1, v0, 5'd0, fnAdd};
                89: instr = {opBeq, zero, zero, 16'hfff7};
                default: instr = '0;
            endcase
        end
    end

endmodule

// ==== dataMem.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module dataMem (
    input  logic              clk,
    input  logic              rst,
    input  mipsPkg::memReq_t  req,
    output mipsPkg::word_t    rdata,
    input  logic              inWrite,
    input  mipsPkg::inData_t  inData,
    output mipsPkg::outByte_t outValue,
    output logic              outStrobe
);

    localparam int AddrBits = $clog2(`MIPS_DMEM_WORDS);

    mipsPkg::word_t mem [`MIPS_DMEM_WORDS];
    mipsPkg::word_t word, byteLane;
    logic [AddrBits-1:0] wordIdx;
    logic [15:0] halfLane;
    logic outHit;

    assign wordIdx = req.addr[AddrBits+1:2];
    assign word = mem[wordIdx];
    assign byteLane = word >> {req.addr[1:0], 3'b000};
    assign halfLane = req.addr[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (req.width)
            mipsPkg::MEM_BYTE: rdata = {{24{req.isSigned & byteLane[7]}}, byteLane[7:0]};
            mipsPkg::MEM_HALF: rdata = {{16{req.isSigned & halfLane[15]}}, halfLane};
            default:           rdata = word;
        endcase
    end

    // CPU store has priority over the input port
    always_ff @(posedge clk) begin
        if (req.write) begin
            case (req.width)
                mipsPkg::MEM_BYTE: mem[wordIdx][{req.addr[1:0], 3'b000} +: 8] <= req.wdata[7:0];
                mipsPkg::MEM_HALF: mem[wordIdx][{req.addr[1], 4'b0000} +: 16] <= req.wdata[15:0];
                default:           mem[wordIdx] <= req.wdata;
            endcase
        end else if (inWrite) begin
            mem[`MIPS_IN_ADDR / 4] <= mipsPkg::word_t'(inData); // Zero extended
        end
    end

    // Output port decode, byte stores only
    assign outHit = req.write && req.width == mipsPkg::MEM_BYTE &&
                    req.addr == `MIPS_OUT_ADDR;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outValue <= '0;
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= outHit;                     // One pulse per store
            if (outHit) outValue <= req.wdata[`MIPS_OUT_WIDTH-1:0];
        end
    end

endmodule

// ==== mipsTop.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module mipsTop (
    input  logic              clk,
    input  logic              rst,
    input  logic              inWrite,
    input  mipsPkg::inData_t  inData,
    output mipsPkg::word_t    pc,
    output mipsPkg::outByte_t outValue,
    output logic              outStrobe
);

    mipsPkg::word_t instr, memRdata;
    mipsPkg::opcode_t opcode;
    mipsPkg::funct_t funct;
    mipsPkg::aluFlags_t flags;
    mipsPkg::ctrl_t ctrl;
    mipsPkg::memReq_t memReq;

    controlUnit i_controlUnit (
        .opcode (opcode),
        .funct  (funct),
        .flags  (flags),
        .ctrl   (ctrl)
    );

    datapath i_datapath (
        .clk    (clk),
        .rst    (rst),
        .instr  (instr),
        .ctrl   (ctrl),
        .rdata  (memRdata),
        .pc     (pc),
        .opcode (opcode),
        .funct  (funct),
        .flags  (flags),
        .memReq (memReq)
    );

    programRom i_programRom (
        .addr  (pc),
        .instr (instr)
    );

    // Data memory with the I/O ports
    dataMem i_dataMem (
        .clk       (clk),
        .rst       (rst),
        .req       (memReq),
        .rdata     (memRdata),
        .inWrite   (inWrite),
        .inData    (inData),
        .outValue  (outValue),
        .outStrobe (outStrobe)
    );

endmodule

// ==== mipsTop_props.sv ====
`timescale 1ns/1ns

module mipsTopProps (
    input logic           clk,
    input logic           rst,
    input mipsPkg::word_t pc,
    input logic           outStrobe
);

    // One pulse per output store
    property strobeSingleCycle;
        @(posedge clk) disable iff (rst) outStrobe |=> !outStrobe;
    endproperty

    property pcAligned;
        @(posedge clk) disable iff (rst) pc[1:0] == 2'b00;
    endproperty

    // Held in reset, and first cycle after release
    property resetState;
        @(posedge clk) rst |=> (pc == '0) && !outStrobe;
    endproperty

    assert property (strobeSingleCycle)
        else $error("outStrobe high in two consecutive cycles");
    assert property (pcAligned)
        else $error("pc not word aligned");
    assert property (resetState)
        else $error("pc or outStrobe not cleared by reset");

endmodule

bind mipsTop mipsTopProps i_mipsTopProps (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .outStrobe (outStrobe)
);

// ==== tb_mipsTop.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module tb_mipsTop;

    localparam int ClkPeriod = 4;
    localparam int NumTests = 5;
    localparam int OutputsPerTest = 9;               // Longest test waits for nine strobes
    localparam int TimeoutNs = NumTests * OutputsPerTest * 300 * ClkPeriod;

    logic clk;
    logic rst;
    logic inWrite;
    mipsPkg::inData_t inData;
    mipsPkg::word_t pc;
    mipsPkg::outByte_t outValue;
    logic outStrobe;

    integer seedVar;
    mipsPkg::outByte_t modelValue;                   // Last expected output byte
    bit seenLcg;
    bit seenMod;

    mipsTop i_mipsTop (
        .clk       (clk),
        .rst       (rst),
        .inWrite   (inWrite),
        .inData    (inData),
        .pc        (pc),
        .outValue  (outValue),
        .outStrobe (outStrobe)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Watchdog sized from the test lengths
    initial begin
        #(TimeoutNs);
        abortRun("Timeout, no output strobe arrived before the time limit");
    end

    // Routine entry points seen on the PC
    always @(negedge clk) begin
        if (!rst && pc == 32'd200) seenLcg = 1'b1;   // lcg(), word 50
        if (!rst && pc == 32'd320) seenMod = 1'b1;   // mod(), word 80
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic checkByte(input string name, input mipsPkg::outByte_t actual,
                             input mipsPkg::outByte_t expected);
        if (actual !== expected) begin
            $display("ERROR: %s = 0x%02h, expected 0x%02h", name, actual, expected);
            abortRun("Byte value mismatch");
        end
    endtask

    task automatic checkWord(input string name, input mipsPkg::word_t actual,
                             input mipsPkg::word_t expected);
        if (actual !== expected) begin
            $display("ERROR: %s = 0x%08h, expected 0x%08h", name, actual, expected);
            abortRun("Word value mismatch");
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR: %s = 0x%01h, expected 0x%01h", name, actual, expected);
            abortRun("Bit value mismatch");
        end
    endtask

    // Reference step, (17 * cur + 3) mod 256
    function automatic mipsPkg::outByte_t lcgStep(input mipsPkg::outByte_t cur);
        int nextVal;
        nextVal = (17 * int'(cur) + 3) % 256;
        return mipsPkg::outByte_t'(nextVal);
    endfunction

    // Programmed ROM regions, in words
    function automatic bit inProgram(input mipsPkg::word_t addr);
        int w;
        w = int'(addr >> 2);
        if (addr[1:0] != 2'b00 || w >= `MIPS_ROM_WORDS) return 1'b0;
        return (w == 0) || (w == 3) || (w >= 10 && w <= 17) ||
               (w >= 50 && w <= 60) || (w >= 80 && w <= 89);
    endfunction

    // Reset for five cycles, seed written in the middle
    task automatic resetWithSeed(input mipsPkg::inData_t seedValue);
        @(posedge clk);
        rst <= 1'b1;
        inWrite <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i == 1) begin
                inWrite <= 1'b1;
                inData <= seedValue;
            end else begin
                inWrite <= 1'b0;
            end
            @(negedge clk);
            checkWord("pc", pc, '0);
            checkBit("outStrobe", outStrobe, 1'b0);
            checkByte("outValue", outValue, '0);
        end
        @(posedge clk);
        rst <= 1'b0;
        inWrite <= 1'b0;
        @(negedge clk);                              // First cycle out of reset
        checkWord("pc", pc, '0);
        checkBit("outStrobe", outStrobe, 1'b0);
        checkByte("outValue", outValue, '0);
    endtask

    task automatic waitStrobe();
        do @(negedge clk); while (outStrobe !== 1'b1);
    endtask

    // Next n outputs against the model
    task automatic expectSequence(input int count);
        for (int n = 0; n < count; n++) begin
            modelValue = lcgStep(modelValue);
            waitStrobe();
            checkByte("outValue", outValue, modelValue);
            if (!inProgram(pc)) begin
                $display("pc = 0x%08h at the strobe", pc);
                abortRun("The pc is outside the programmed ROM regions at an output strobe");
            end
        end
    endtask

    task automatic testResetState();
        resetWithSeed('0);
    endtask

    task automatic testFirstResult();
        mipsPkg::inData_t s;
        s = mipsPkg::inData_t'($random(seedVar));
        s[`MIPS_IN_WIDTH-1:8] = '0;
        resetWithSeed(s);
        modelValue = s[7:0];
        expectSequence(1);
    endtask

    task automatic testRecurrence();
        expectSequence(8);                           // Continues from the first result
    endtask

    task automatic testLowByteOnly();
        mipsPkg::inData_t wide;
        wide = mipsPkg::inData_t'($random(seedVar));
        wide[`MIPS_IN_WIDTH-1] = 1'b1;               // Upper bits must be ignored
        resetWithSeed(wide);
        modelValue = wide[7:0];
        expectSequence(1);
        resetWithSeed(mipsPkg::inData_t'(wide[7:0]));
        modelValue = wide[7:0];
        expectSequence(1);
    endtask

    task automatic testReseed();
        mipsPkg::inData_t s;
        s = mipsPkg::inData_t'($random(seedVar));
        resetWithSeed(s);
        modelValue = s[7:0];
        expectSequence(2);
        @(posedge clk);
        inWrite <= 1'b1;                             // Late write, program never rereads
        inData <= mipsPkg::inData_t'($random(seedVar));
        @(posedge clk);
        inWrite <= 1'b0;
        expectSequence(3);
    endtask

    initial begin
        seedVar = 4;
        rst = 1'b1;
        inWrite = 1'b0;
        inData = '0;
        seenLcg = 1'b0;
        seenMod = 1'b0;
        modelValue = '0;
        testResetState();
        testFirstResult();
        testRecurrence();
        testLowByteOnly();
        testReseed();
        if (!(seenLcg && seenMod)) begin
            abortRun("The pc never reached both the LCG routine and the mod routine");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== src.f ====
+incdir+.
mipsPkg.sv
controlUnit.sv
regFile.sv
alu.sv
datapath.sv
programRom.sv
dataMem.sv
mipsTop.sv
mipsTop_props.sv
tb_mipsTop.sv
